// ==== sim.f ====
rtl/jfive_pkg.sv
rtl/ctl_regs.sv
rtl/tcm_ram.sv
rtl/tcm_fetch_port.sv
rtl/tcm_data_port.sv
rtl/jfive_controller.sv
verif/tb_clock_gen.sv
verif/jfive_controller_sva.sv
verif/jfive_controller_tb.sv

// ==== Makefile ====
obj_dir/Vjfive_controller_tb: sim.f rtl/*.sv verif/*.sv
	verilator --binary --timing --assert --top-module jfive_controller_tb \
		-f sim.f -o Vjfive_controller_tb

run: obj_dir/Vjfive_controller_tb
	./obj_dir/Vjfive_controller_tb > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== verif/jfive_controller_tb.sv ====
`timescale 1ns/1ps

module jfive_controller_tb import jfive_pkg::*; ();

    localparam int NUM_ROWS    = 29;
    localparam int WAIT_CYCLES = 20;
    localparam int CLK_PERIOD  = 20;

    typedef enum {
        OP_CTL_WR, OP_CTL_RD, OP_HOST_WR, OP_HOST_RD,
        OP_FETCH, OP_DATA_WR, OP_DATA_RD, OP_STALL
    } op_e;

    typedef struct {
        op_e         op;
        logic [31:0] addr;
        word_t       data;
        strb_t       strb;
        word_t       exp;
    } row_t;

    logic       clk;
    logic       reset;

    ctl_addr_t  ctl_awaddr;
    logic       ctl_awvalid;
    logic       ctl_awready;
    word_t      ctl_wdata;
    strb_t      ctl_wstrb;
    logic       ctl_wvalid;
    logic       ctl_wready;
    logic       ctl_bvalid;
    logic       ctl_bready;
    ctl_addr_t  ctl_araddr;
    logic       ctl_arvalid;
    logic       ctl_arready;
    word_t      ctl_rdata;
    logic       ctl_rvalid;
    logic       ctl_rready;

    logic       mem_cvalid;
    tcm_addr_t  mem_caddr;
    logic       mem_cread;
    strb_t      mem_cstrb;
    word_t      mem_cdata;
    logic       mem_rvalid;
    word_t      mem_rdata;
    logic       mem_rready;

    thread_id_t ibus_aid;
    pc_t        ibus_apc;
    logic       ibus_avalid;
    logic       ibus_aready;
    thread_id_t ibus_rid;
    pc_t        ibus_rpc;
    word_t      ibus_rinstr;
    logic       ibus_rvalid;
    logic       ibus_rready;

    tcm_addr_t  dbus_aaddr;
    logic       dbus_aread;
    strb_t      dbus_wstrb;
    word_t      dbus_wdata;
    logic       dbus_aready;
    word_t      dbus_rdata;
    logic       dbus_rvalid;
    logic       dbus_rready;

    logic       core_reset;

    row_t       rows [NUM_ROWS];
    word_t      ref_mem [0:(2**TCM_ADDR_BITS)-1];
    logic       ctl_model;
    int         row_errors;
    int         pass_count;
    int         fail_count;

    tb_clock_gen u_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    jfive_controller u_jfive_controller (.*);

    // --------------------------------------------------
    // check helpers
    // --------------------------------------------------
    task automatic check_value(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s expected %h got %h", $time, name, exp, got);
            row_errors++;
        end
    endtask

    task automatic report_missing(input string what);
        $display("no %s within %0d cycles at %0t ns", what, WAIT_CYCLES, $time);
        row_errors++;
    endtask

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // port 0 moves unless a response waits
    function automatic logic port0_free();
        return !(ibus_rvalid && !ibus_rready) && !(mem_rvalid && !mem_rready);
    endfunction

    function automatic string op_name(op_e op);
        case (op)
            OP_CTL_WR:  return "ctl_wr";
            OP_CTL_RD:  return "ctl_rd";
            OP_HOST_WR: return "host_wr";
            OP_HOST_RD: return "host_rd";
            OP_FETCH:   return "fetch";
            OP_DATA_WR: return "data_wr";
            OP_DATA_RD: return "data_rd";
            default:    return "stall";
        endcase
    endfunction

    // --------------------------------------------------
    // control slave
    // --------------------------------------------------
    task automatic ctl_write(input logic [31:0] addr, input word_t data, input strb_t strb);
        int   n;
        logic old_reset;
        @(posedge clk);
        ctl_awaddr  <= ctl_addr_t'(addr);
        ctl_wdata   <= data;
        ctl_wstrb   <= strb;
        ctl_awvalid <= 1'b1;
        ctl_wvalid  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(ctl_awready && ctl_wready) && n < WAIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        old_reset = core_reset;
        @(posedge clk);
        ctl_awvalid <= 1'b0;
        ctl_wvalid  <= 1'b0;
        if (n >= WAIT_CYCLES) begin
            report_missing("write accept");
            return;
        end
        if (addr == 32'h10 && strb[0]) begin
            ctl_model = data[0];
        end
        @(negedge clk);
        check_value("ctl_bvalid", 32'd1, word_t'(ctl_bvalid));
        // core reset moves on the third edge
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            if (i < 3) begin
                check_value("core_reset", word_t'(old_reset), word_t'(core_reset));
            end else begin
                check_value("core_reset", word_t'(!ctl_model), word_t'(core_reset));
            end
        end
    endtask

    task automatic ctl_read(input logic [31:0] addr, input word_t exp);
        int n;
        @(posedge clk);
        ctl_araddr  <= ctl_addr_t'(addr);
        ctl_arvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!ctl_arready && n < WAIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        ctl_arvalid <= 1'b0;
        @(negedge clk);
        if (!ctl_rvalid) begin
            report_missing("ctl_rvalid one cycle after read");
        end else begin
            check_value("ctl_rdata", exp, ctl_rdata);
        end
    endtask

    // --------------------------------------------------
    // host memory port
    // --------------------------------------------------
    task automatic host_command(input logic [31:0] addr, input word_t data,
                                input strb_t strb, input logic rd);
        int n;
        @(posedge clk);
        mem_cvalid <= 1'b1;
        mem_caddr  <= tcm_addr_t'(addr);
        mem_cread  <= rd;
        mem_cstrb  <= strb;
        mem_cdata  <= data;
        n = 0;
        @(negedge clk);
        while (!port0_free() && n < WAIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        mem_cvalid <= 1'b0;
        mem_cread  <= 1'b0;
        mem_cstrb  <= '0;
        if (n >= WAIT_CYCLES) begin
            report_missing("port 0 advance");
        end
    endtask

    task automatic host_read(input logic [31:0] addr);
        int lat;
        host_command(addr, '0, '0, 1'b1);
        lat = 1;
        @(negedge clk);
        while (!mem_rvalid && lat < WAIT_CYCLES) begin
            @(negedge clk);
            lat++;
        end
        if (!mem_rvalid) begin
            report_missing("mem_rvalid");
            return;
        end
        check_value("mem_rvalid latency", word_t'(TCM_LATENCY), word_t'(lat));
        check_value("mem_rdata", ref_mem[tcm_addr_t'(addr)], mem_rdata);
        @(negedge clk);
        check_value("mem_rvalid", 32'd0, word_t'(mem_rvalid));
    endtask

    // --------------------------------------------------
    // instruction bus
    // --------------------------------------------------
    task automatic wait_fetch_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!ibus_aready && n < WAIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_CYCLES) begin
            report_missing("ibus_aready");
        end
        @(posedge clk);
    endtask

    task automatic collect_fetch(input tcm_addr_t addr, input thread_id_t tid,
                                 input logic check_lat);
        int lat;
        lat = 1;
        @(negedge clk);
        while (!ibus_rvalid && lat < WAIT_CYCLES) begin
            @(negedge clk);
            lat++;
        end
        if (!ibus_rvalid) begin
            report_missing("ibus_rvalid");
            return;
        end
        if (check_lat) begin
            check_value("ibus_rvalid latency", word_t'(TCM_LATENCY), word_t'(lat));
        end
        check_value("ibus_rid", word_t'(tid), word_t'(ibus_rid));
        check_value("ibus_rpc", pc_t'(addr) << 2, ibus_rpc);
        check_value("ibus_rinstr", ref_mem[addr], ibus_rinstr);
    endtask

    task automatic fetch(input logic [31:0] addr, input thread_id_t tid);
        @(posedge clk);
        ibus_aid    <= tid;
        ibus_apc    <= pc_t'(tcm_addr_t'(addr)) << 2;
        ibus_avalid <= 1'b1;
        wait_fetch_accept();
        ibus_avalid <= 1'b0;
        collect_fetch(tcm_addr_t'(addr), tid, 1'b1);
    endtask

    task automatic fetch_stall(input logic [31:0] addr);
        word_t held_instr;
        pc_t   held_pc;
        @(posedge clk);
        ibus_rready <= 1'b0;
        ibus_aid    <= 2'd0;
        ibus_apc    <= pc_t'(tcm_addr_t'(addr)) << 2;
        ibus_avalid <= 1'b1;
        wait_fetch_accept();
        ibus_aid    <= 2'd1;
        ibus_apc    <= pc_t'(tcm_addr_t'(addr + 1)) << 2;
        wait_fetch_accept();
        ibus_avalid <= 1'b0;
        collect_fetch(tcm_addr_t'(addr), 2'd0, 1'b0);
        held_instr = ibus_rinstr;
        held_pc    = ibus_rpc;
        repeat (4) begin
            @(negedge clk);
            check_value("ibus_rvalid", 32'd1, word_t'(ibus_rvalid));
            check_value("ibus_rinstr", held_instr, ibus_rinstr);
            check_value("ibus_rpc", held_pc, ibus_rpc);
        end
        @(posedge clk);
        ibus_rready <= 1'b1;
        // drain in issue order
        for (int k = 0; k < 2; k++) begin
            collect_fetch(tcm_addr_t'(addr + k), thread_id_t'(k), 1'b0);
            @(posedge clk);
        end
        @(negedge clk);
        check_value("ibus_rvalid", 32'd0, word_t'(ibus_rvalid));
    endtask

    // --------------------------------------------------
    // data bus
    // --------------------------------------------------
    task automatic data_access(input logic [31:0] addr, input word_t data,
                               input strb_t strb, input logic rd);
        int n;
        @(posedge clk);
        dbus_aaddr <= tcm_addr_t'(addr);
        dbus_wdata <= data;
        dbus_wstrb <= strb;
        dbus_aread <= rd;
        n = 0;
        @(negedge clk);
        while (!dbus_aready && n < WAIT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        dbus_wstrb <= '0;
        dbus_aread <= 1'b0;
        if (n >= WAIT_CYCLES) begin
            report_missing("dbus_aready");
        end
    endtask

    task automatic data_read(input logic [31:0] addr);
        int lat;
        data_access(addr, '0, '0, 1'b1);
        lat = 1;
        @(negedge clk);
        while (!dbus_rvalid && lat < WAIT_CYCLES) begin
            @(negedge clk);
            lat++;
        end
        if (!dbus_rvalid) begin
            report_missing("dbus_rvalid");
            return;
        end
        check_value("dbus_rvalid latency", word_t'(TCM_LATENCY), word_t'(lat));
        check_value("dbus_rdata", ref_mem[tcm_addr_t'(addr)], dbus_rdata);
    endtask

    // --------------------------------------------------
    // stimulus table
    // --------------------------------------------------
    task automatic build_table();
        rows[0]  = '{OP_CTL_RD,  32'h00,  '0, 4'hf, CORE_ID};
        rows[1]  = '{OP_CTL_RD,  32'h04,  '0, 4'hf, CORE_VERSION};
        rows[2]  = '{OP_CTL_RD,  32'h3c,  '0, 4'hf, 32'd0};
        rows[3]  = '{OP_CTL_RD,  32'h14,  '0, 4'hf, 32'd0};
        rows[4]  = '{OP_CTL_WR,  32'h10,  32'd1, 4'hf, '0};
        rows[5]  = '{OP_CTL_RD,  32'h10,  '0, 4'hf, 32'd1};
        rows[6]  = '{OP_CTL_RD,  32'h14,  '0, 4'hf, 32'd1};
        rows[7]  = '{OP_HOST_WR, 32'h010, '0, 4'hf, '0};
        rows[8]  = '{OP_HOST_WR, 32'h011, '0, 4'hf, '0};
        rows[9]  = '{OP_HOST_WR, 32'h012, '0, 4'hf, '0};
        rows[10] = '{OP_HOST_WR, 32'h013, '0, 4'hf, '0};
        rows[11] = '{OP_HOST_WR, 32'h3ff, '0, 4'hf, '0};
        rows[12] = '{OP_HOST_RD, 32'h010, '0, 4'h0, '0};
        rows[13] = '{OP_HOST_RD, 32'h011, '0, 4'h0, '0};
        rows[14] = '{OP_HOST_RD, 32'h012, '0, 4'h0, '0};
        rows[15] = '{OP_HOST_RD, 32'h013, '0, 4'h0, '0};
        rows[16] = '{OP_HOST_RD, 32'h3ff, '0, 4'h0, '0};
        // data field carries the thread id
        rows[17] = '{OP_FETCH,   32'h010, 32'd0, 4'h0, '0};
        rows[18] = '{OP_FETCH,   32'h011, 32'd1, 4'h0, '0};
        rows[19] = '{OP_FETCH,   32'h012, 32'd2, 4'h0, '0};
        rows[20] = '{OP_FETCH,   32'h013, 32'd3, 4'h0, '0};
        rows[21] = '{OP_DATA_WR, 32'h011, 32'hdead_beef, 4'b0101, '0};
        rows[22] = '{OP_DATA_RD, 32'h011, '0, 4'h0, '0};
        rows[23] = '{OP_FETCH,   32'h011, 32'd1, 4'h0, '0};
        rows[24] = '{OP_DATA_WR, 32'h012, 32'ha5a5_5a5a, 4'b1100, '0};
        rows[25] = '{OP_DATA_RD, 32'h012, '0, 4'h0, '0};
        rows[26] = '{OP_STALL,   32'h010, '0, 4'h0, '0};
        rows[27] = '{OP_CTL_WR,  32'h10,  32'd0, 4'hf, '0};
        rows[28] = '{OP_CTL_RD,  32'h14,  '0, 4'hf, 32'd0};
    endtask

    initial begin
        word_t rnd;
        void'($urandom(32'hf06c));
        ctl_awaddr  <= '0;
        ctl_awvalid <= 1'b0;
        ctl_wdata   <= '0;
        ctl_wstrb   <= '0;
        ctl_wvalid  <= 1'b0;
        ctl_bready  <= 1'b1;
        ctl_araddr  <= '0;
        ctl_arvalid <= 1'b0;
        ctl_rready  <= 1'b1;
        mem_cvalid  <= 1'b0;
        mem_caddr   <= '0;
        mem_cread   <= 1'b0;
        mem_cstrb   <= '0;
        mem_cdata   <= '0;
        mem_rready  <= 1'b1;
        ibus_aid    <= '0;
        ibus_apc    <= '0;
        ibus_avalid <= 1'b0;
        ibus_rready <= 1'b1;
        dbus_aaddr  <= '0;
        dbus_aread  <= 1'b0;
        dbus_wstrb  <= '0;
        dbus_wdata  <= '0;
        dbus_rready <= 1'b1;
        ctl_model   = 1'b0;
        pass_count  = 0;
        fail_count  = 0;
        build_table();

        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            row_errors = 0;
            case (rows[i].op)
                OP_CTL_WR:  ctl_write(rows[i].addr, rows[i].data, rows[i].strb);
                OP_CTL_RD:  ctl_read(rows[i].addr, rows[i].exp);
                OP_HOST_WR: begin
                    rnd = $urandom;
                    host_command(rows[i].addr, rnd, rows[i].strb, 1'b0);
                    ref_mem[tcm_addr_t'(rows[i].addr)] = merge_bytes(
                        ref_mem[tcm_addr_t'(rows[i].addr)], rnd, rows[i].strb);
                end
                OP_HOST_RD: host_read(rows[i].addr);
                OP_FETCH:   fetch(rows[i].addr, thread_id_t'(rows[i].data));
                OP_DATA_WR: begin
                    data_access(rows[i].addr, rows[i].data, rows[i].strb, 1'b0);
                    ref_mem[tcm_addr_t'(rows[i].addr)] = merge_bytes(
                        ref_mem[tcm_addr_t'(rows[i].addr)], rows[i].data, rows[i].strb);
                end
                OP_DATA_RD: data_read(rows[i].addr);
                default:    fetch_stall(rows[i].addr);
            endcase
            if (row_errors == 0) begin
                pass_count++;
                $display("row %0d %s addr %h passed", i, op_name(rows[i].op), rows[i].addr);
            end else begin
                fail_count++;
                $display("row %0d %s addr %h failed with %0d errors",
                         i, op_name(rows[i].op), rows[i].addr, row_errors);
            end
        end

        $display("rows passed %0d, rows failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog allows 40 cycles per row plus reset
    initial begin
        #((NUM_ROWS * 40 + 10) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", NUM_ROWS * 40 + 10);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verif/jfive_controller_sva.sv ====
`timescale 1ns/1ps

module jfive_controller_sva import jfive_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  ctl_awvalid,
    input logic  ctl_awready,
    input logic  ctl_wvalid,
    input logic  ctl_wready,
    input logic  ctl_bvalid,
    input logic  ctl_rvalid,
    input logic  mem_rvalid,
    input logic  ibus_rvalid,
    input logic  ibus_rready,
    input word_t ibus_rinstr,
    input logic  dbus_rvalid,
    input logic  core_reset
);

    // all valids low and core held after a reset edge
    assert property (@(posedge clk)
        reset |=> !ctl_bvalid && !ctl_rvalid && !mem_rvalid && !ibus_rvalid
                  && !dbus_rvalid && core_reset)
        else $error("valid output high during reset");

    assert property (@(posedge clk) disable iff (reset)
        (ctl_awvalid && ctl_awready && ctl_wvalid && ctl_wready) |=> ctl_bvalid)
        else $error("ctl_bvalid missing after accepted write");

    // stalled fetch response holds
    assert property (@(posedge clk) disable iff (reset)
        (ibus_rvalid && !ibus_rready) |=> ibus_rvalid && $stable(ibus_rinstr))
        else $error("fetch response changed while stalled");

endmodule

bind jfive_controller jfive_controller_sva u_jfive_controller_sva (
    .clk         (clk),
    .reset       (reset),
    .ctl_awvalid (ctl_awvalid),
    .ctl_awready (ctl_awready),
    .ctl_wvalid  (ctl_wvalid),
    .ctl_wready  (ctl_wready),
    .ctl_bvalid  (ctl_bvalid),
    .ctl_rvalid  (ctl_rvalid),
    .mem_rvalid  (mem_rvalid),
    .ibus_rvalid (ibus_rvalid),
    .ibus_rready (ibus_rready),
    .ibus_rinstr (ibus_rinstr),
    .dbus_rvalid (dbus_rvalid),
    .core_reset  (core_reset)
);

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for three rising edges
    initial begin
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== rtl/jfive_controller.sv ====
`timescale 1ns/1ps

module jfive_controller import jfive_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // control slave
    input  ctl_addr_t  ctl_awaddr,
    input  logic       ctl_awvalid,
    output logic       ctl_awready,
    input  word_t      ctl_wdata,
    input  strb_t      ctl_wstrb,
    input  logic       ctl_wvalid,
    output logic       ctl_wready,
    output logic       ctl_bvalid,
    input  logic       ctl_bready,
    input  ctl_addr_t  ctl_araddr,
    input  logic       ctl_arvalid,
    output logic       ctl_arready,
    output word_t      ctl_rdata,
    output logic       ctl_rvalid,
    input  logic       ctl_rready,

    // host memory port
    input  logic       mem_cvalid,
    input  tcm_addr_t  mem_caddr,
    input  logic       mem_cread,
    input  strb_t      mem_cstrb,
    input  word_t      mem_cdata,
    output logic       mem_rvalid,
    output word_t      mem_rdata,
    input  logic       mem_rready,

    // instruction bus
    input  thread_id_t ibus_aid,
    input  pc_t        ibus_apc,
    input  logic       ibus_avalid,
    output logic       ibus_aready,
    output thread_id_t ibus_rid,
    output pc_t        ibus_rpc,
    output word_t      ibus_rinstr,
    output logic       ibus_rvalid,
    input  logic       ibus_rready,

    // data bus
    input  tcm_addr_t  dbus_aaddr,
    input  logic       dbus_aread,
    input  strb_t      dbus_wstrb,
    input  word_t      dbus_wdata,
    output logic       dbus_aready,
    output word_t      dbus_rdata,
    output logic       dbus_rvalid,
    input  logic       dbus_rready,

    output logic       core_reset
);

    logic      p0_en;
    strb_t     p0_we;
    tcm_addr_t p0_addr;
    word_t     p0_din;
    word_t     p0_dout;

    logic      p1_en;
    strb_t     p1_we;
    tcm_addr_t p1_addr;
    word_t     p1_din;
    word_t     p1_dout;

    // --------------------------------------------------
    // control registers
    // --------------------------------------------------
    ctl_regs u_ctl_regs (
        .clk         (clk),
        .reset       (reset),
        .ctl_awaddr  (ctl_awaddr),
        .ctl_awvalid (ctl_awvalid),
        .ctl_awready (ctl_awready),
        .ctl_wdata   (ctl_wdata),
        .ctl_wstrb   (ctl_wstrb),
        .ctl_wvalid  (ctl_wvalid),
        .ctl_wready  (ctl_wready),
        .ctl_bvalid  (ctl_bvalid),
        .ctl_bready  (ctl_bready),
        .ctl_araddr  (ctl_araddr),
        .ctl_arvalid (ctl_arvalid),
        .ctl_arready (ctl_arready),
        .ctl_rdata   (ctl_rdata),
        .ctl_rvalid  (ctl_rvalid),
        .ctl_rready  (ctl_rready),
        .core_reset  (core_reset)
    );

    // --------------------------------------------------
    // tcm and its two ports
    // --------------------------------------------------
    tcm_ram u_tcm_ram (
        .clk     (clk),
        .p0_en   (p0_en),
        .p0_we   (p0_we),
        .p0_addr (p0_addr),
        .p0_din  (p0_din),
        .p0_dout (p0_dout),
        .p1_en   (p1_en),
        .p1_we   (p1_we),
        .p1_addr (p1_addr),
        .p1_din  (p1_din),
        .p1_dout (p1_dout)
    );

    // fetch and host share port 0
    tcm_fetch_port u_tcm_fetch_port (
        .clk         (clk),
        .reset       (reset),
        .ibus_aid    (ibus_aid),
        .ibus_apc    (ibus_apc),
        .ibus_avalid (ibus_avalid),
        .ibus_aready (ibus_aready),
        .ibus_rid    (ibus_rid),
        .ibus_rpc    (ibus_rpc),
        .ibus_rinstr (ibus_rinstr),
        .ibus_rvalid (ibus_rvalid),
        .ibus_rready (ibus_rready),
        .mem_cvalid  (mem_cvalid),
        .mem_caddr   (mem_caddr),
        .mem_cread   (mem_cread),
        .mem_cstrb   (mem_cstrb),
        .mem_cdata   (mem_cdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .mem_rready  (mem_rready),
        .ram_en      (p0_en),
        .ram_we      (p0_we),
        .ram_addr    (p0_addr),
        .ram_din     (p0_din),
        .ram_dout    (p0_dout)
    );

    tcm_data_port u_tcm_data_port (
        .clk         (clk),
        .reset       (reset),
        .dbus_aaddr  (dbus_aaddr),
        .dbus_aread  (dbus_aread),
        .dbus_wstrb  (dbus_wstrb),
        .dbus_wdata  (dbus_wdata),
        .dbus_aready (dbus_aready),
        .dbus_rdata  (dbus_rdata),
        .dbus_rvalid (dbus_rvalid),
        .dbus_rready (dbus_rready),
        .ram_en      (p1_en),
        .ram_we      (p1_we),
        .ram_addr    (p1_addr),
        .ram_din     (p1_din),
        .ram_dout    (p1_dout)
    );

endmodule

// ==== rtl/tcm_data_port.sv ====
`timescale 1ns/1ps

module tcm_data_port import jfive_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // load/store bus
    input  tcm_addr_t dbus_aaddr,
    input  logic      dbus_aread,
    input  strb_t     dbus_wstrb,
    input  word_t     dbus_wdata,
    output logic      dbus_aready,
    output word_t     dbus_rdata,
    output logic      dbus_rvalid,
    input  logic      dbus_rready,

    // ram port 1
    output logic      ram_en,
    output strb_t     ram_we,
    output tcm_addr_t ram_addr,
    output word_t     ram_din,
    input  word_t     ram_dout
);

    logic [TCM_LATENCY-1:0] read_valid;

    // stall only on a waiting response
    assign dbus_aready = !dbus_rvalid || dbus_rready;

    assign ram_en   = dbus_aready;
    assign ram_we   = dbus_wstrb;
    assign ram_addr = dbus_aaddr;
    assign ram_din  = dbus_wdata;

    // read tag follows the ram pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            read_valid <= '0;
        end else if (dbus_aready) begin
            read_valid <= {read_valid[TCM_LATENCY-2:0], dbus_aread};
        end
    end

    assign dbus_rdata  = ram_dout;
    assign dbus_rvalid = read_valid[TCM_LATENCY-1];

endmodule

// ==== rtl/tcm_fetch_port.sv ====
`timescale 1ns/1ps

module tcm_fetch_port import jfive_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // instruction fetch
    input  thread_id_t ibus_aid,
    input  pc_t        ibus_apc,
    input  logic       ibus_avalid,
    output logic       ibus_aready,
    output thread_id_t ibus_rid,
    output pc_t        ibus_rpc,
    output word_t      ibus_rinstr,
    output logic       ibus_rvalid,
    input  logic       ibus_rready,

    // host memory port
    input  logic       mem_cvalid,
    input  tcm_addr_t  mem_caddr,
    input  logic       mem_cread,
    input  strb_t      mem_cstrb,
    input  word_t      mem_cdata,
    output logic       mem_rvalid,
    output word_t      mem_rdata,
    input  logic       mem_rready,

    // ram port 0
    output logic       ram_en,
    output strb_t      ram_we,
    output tcm_addr_t  ram_addr,
    output word_t      ram_din,
    input  word_t      ram_dout
);

    logic                              advance;
    logic                              fetch_take;
    logic       [TCM_LATENCY-1:0]      fetch_valid;
    logic       [TCM_LATENCY-1:0]      host_valid;
    thread_id_t [TCM_LATENCY-1:0]      fetch_id;
    pc_t        [TCM_LATENCY-1:0]      fetch_pc;

    // freeze the whole port while either response waits
    assign advance = !(ibus_rvalid && !ibus_rready) && !(mem_rvalid && !mem_rready);

    // host wins over fetch
    assign ibus_aready = advance && !mem_cvalid;
    assign fetch_take  = ibus_avalid && ibus_aready;

    // --------------------------------------------------
    // ram command
    // --------------------------------------------------
    assign ram_en   = advance;
    assign ram_we   = mem_cvalid ? mem_cstrb : '0;
    assign ram_addr = mem_cvalid ? mem_caddr : tcm_addr_t'(ibus_apc >> 2);
    assign ram_din  = mem_cdata;

    // --------------------------------------------------
    // tags in step with the ram
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= '0;
            host_valid  <= '0;
        end else if (advance) begin
            fetch_valid <= {fetch_valid[TCM_LATENCY-2:0], fetch_take};
            host_valid  <= {host_valid[TCM_LATENCY-2:0], mem_cvalid && mem_cread};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_id[0] <= ibus_aid;
            fetch_pc[0] <= ibus_apc;
            for (int i = 1; i < TCM_LATENCY; i++) begin
                fetch_id[i] <= fetch_id[i-1];
                fetch_pc[i] <= fetch_pc[i-1];
            end
        end
    end

    // responses
    assign ibus_rid    = fetch_id[TCM_LATENCY-1];
    assign ibus_rpc    = fetch_pc[TCM_LATENCY-1];
    assign ibus_rinstr = ram_dout;
    assign ibus_rvalid = fetch_valid[TCM_LATENCY-1];

    assign mem_rdata   = ram_dout;
    assign mem_rvalid  = host_valid[TCM_LATENCY-1];

endmodule

// ==== rtl/tcm_ram.sv ====
`timescale 1ns/1ps

module tcm_ram import jfive_pkg::*; (
    input  logic      clk,

    input  logic      p0_en,
    input  strb_t     p0_we,
    input  tcm_addr_t p0_addr,
    input  word_t     p0_din,
    output word_t     p0_dout,

    input  logic      p1_en,
    input  strb_t     p1_we,
    input  tcm_addr_t p1_addr,
    input  word_t     p1_din,
    output word_t     p1_dout
);

    word_t     mem [0:(2**TCM_ADDR_BITS)-1];

    // ports gathered so both share one access loop
    logic      en   [2];
    strb_t     we   [2];
    tcm_addr_t addr [2];
    word_t     din  [2];
    word_t     ram_q [2];
    word_t     dout  [2];

    assign en[0]   = p0_en;
    assign we[0]   = p0_we;
    assign addr[0] = p0_addr;
    assign din[0]  = p0_din;
    assign en[1]   = p1_en;
    assign we[1]   = p1_we;
    assign addr[1] = p1_addr;
    assign din[1]  = p1_din;

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (en[p]) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (we[p][b]) begin
                        mem[addr[p]][8*b +: 8] <= din[p][8*b +: 8];
                    end
                end
                // read first, then output register
                ram_q[p] <= mem[addr[p]];
                dout[p]  <= ram_q[p];
            end
        end
    end

    assign p0_dout = dout[0];
    assign p1_dout = dout[1];

endmodule

// ==== rtl/ctl_regs.sv ====
`timescale 1ns/1ps

module ctl_regs import jfive_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  ctl_addr_t ctl_awaddr,
    input  logic      ctl_awvalid,
    output logic      ctl_awready,
    input  word_t     ctl_wdata,
    input  strb_t     ctl_wstrb,
    input  logic      ctl_wvalid,
    output logic      ctl_wready,
    output logic      ctl_bvalid,
    input  logic      ctl_bready,

    input  ctl_addr_t ctl_araddr,
    input  logic      ctl_arvalid,
    output logic      ctl_arready,
    output word_t     ctl_rdata,
    output logic      ctl_rvalid,
    input  logic      ctl_rready,

    output logic      core_reset
);

    regadr_t wr_regadr;
    regadr_t rd_regadr;
    logic    b_free;
    logic    wr_accept;
    logic    rd_accept;
    logic    ctl_control;
    logic    sync_ff0;
    logic    sync_ff1;

    // byte address to word index
    assign wr_regadr = regadr_t'(ctl_awaddr >> 2);
    assign rd_regadr = regadr_t'(ctl_araddr >> 2);

    // --------------------------------------------------
    // write channel
    // --------------------------------------------------
    assign b_free      = !ctl_bvalid || ctl_bready;
    assign ctl_awready = b_free && ctl_wvalid;
    assign ctl_wready  = b_free && ctl_awvalid;
    assign wr_accept   = ctl_awvalid && ctl_awready && ctl_wvalid && ctl_wready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_control <= 1'b0;
        end else if (wr_accept) begin
            // only byte 0 holds a writable bit
            if (wr_regadr == REGADR_CTL_CONTROL && ctl_wstrb[0]) begin
                ctl_control <= ctl_wdata[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_bvalid <= 1'b0;
        end else begin
            if (ctl_bready) begin
                ctl_bvalid <= 1'b0;
            end
            if (wr_accept) begin
                ctl_bvalid <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // read channel
    // --------------------------------------------------
    assign ctl_arready = !ctl_rvalid || ctl_rready;
    assign rd_accept   = ctl_arvalid && ctl_arready;

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            case (rd_regadr)
                REGADR_CORE_ID:      ctl_rdata <= CORE_ID;
                REGADR_CORE_VERSION: ctl_rdata <= CORE_VERSION;
                REGADR_CTL_CONTROL:  ctl_rdata <= {{($bits(word_t)-1){1'b0}}, ctl_control};
                REGADR_CTL_STATUS:   ctl_rdata <= {{($bits(word_t)-1){1'b0}}, ~core_reset};
                default:             ctl_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_rvalid <= 1'b0;
        end else begin
            if (ctl_rready) begin
                ctl_rvalid <= 1'b0;
            end
            if (rd_accept) begin
                ctl_rvalid <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // core reset
    // --------------------------------------------------
    // two sync flops, then the output register
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_ff0   <= 1'b1;
            sync_ff1   <= 1'b1;
            core_reset <= 1'b1;
        end else begin
            sync_ff0   <= ~ctl_control;
            sync_ff1   <= sync_ff0;
            core_reset <= sync_ff1;
        end
    end

endmodule

// ==== rtl/jfive_pkg.sv ====
package jfive_pkg;

    // --------------------------------------------------
    // data widths
    // --------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [31:0] pc_t;

    // tcm word address, 4 KiB
    localparam int TCM_ADDR_BITS = 10;
    typedef logic [TCM_ADDR_BITS-1:0] tcm_addr_t;

    // cycles from accepted access to response
    localparam int TCM_LATENCY = 2;

    // hardware threads
    localparam int THREADS = 4;
    typedef logic [$clog2(THREADS)-1:0] thread_id_t;

    // --------------------------------------------------
    // control register map
    // --------------------------------------------------
    typedef logic [7:0] ctl_addr_t;
    typedef logic [4:0] regadr_t;

    localparam regadr_t REGADR_CORE_ID      = 5'h00;
    localparam regadr_t REGADR_CORE_VERSION = 5'h01;
    localparam regadr_t REGADR_CTL_CONTROL  = 5'h04;
    localparam regadr_t REGADR_CTL_STATUS   = 5'h05;

    // --------------------------------------------------
    // identity
    // --------------------------------------------------
    localparam word_t CORE_ID      = 32'h527a_ffff;
    localparam word_t CORE_VERSION = 32'h0001_0000;

endpackage
